/* design/numFormatPkg.sv */
// Number formats shared by the reciprocal and the perspective multiply datapath
package numFormatPkg;

    // Width of 1/w, w, s/w and t/w, all unsigned fixed point
    localparam int NumberWidth = 16;

    // Number of operand bits that select a reciprocal table sample
    localparam int LookupPrecision = 11;

    // Remaining low bits give the position between two samples
    localparam int InterpolationWidth = NumberWidth - LookupPrecision;

    // Number of samples held in each reciprocal table
    localparam int LookupSize = 2 ** LookupPrecision;

    // Width of the reciprocal numerator
    localparam int NumeratorWidth = 24;

    // Numerator used when the top level does not override it
    localparam logic [NumeratorWidth-1:0] DefaultNumerator = '1;

    // Operand split into table index and interpolation fraction
    typedef struct packed {
        logic [LookupPrecision-1:0]    index;
        logic [InterpolationWidth-1:0] frac;
    } recipFields_t;

    // The reciprocal operand is either taken as a plain number or
    // decoded into a table index and a fraction between samples
    typedef union packed {
        logic [NumberWidth-1:0] raw;
        recipFields_t           fields;
    } recipOperand_t;

endpackage

/* design/texCoordPkg.sv */
// Texture coordinate format and wrap mode encoding
package texCoordPkg;

    // Fractional bits of the perspective corrected s and t
    localparam int CoordFracBits = 8;

    // Integer bits left over for the texel position
    localparam int CoordIntBits = numFormatPkg::NumberWidth - CoordFracBits;

    // How a coordinate outside the texture is folded back in
    // Repeat keeps the low index bits, clamp sticks to the last texel
    typedef enum logic {
        WrapRepeat = 1'b0,
        WrapClamp  = 1'b1
    } wrapMode_t;

endpackage

/* design/recip.sv */
// Reciprocal by table lookup with linear interpolation between samples
`timescale 1ns/1ps

module recip #(
    // Fixed point numerator of the quotient
    parameter int unsigned NUMERATOR = numFormatPkg::DefaultNumerator
)
(
    input  logic [numFormatPkg::NumberWidth-1:0] x,
    output logic [numFormatPkg::NumberWidth-1:0] y
);

    localparam int Nw = numFormatPkg::NumberWidth;
    localparam int Iw = numFormatPkg::InterpolationWidth;
    localparam int Entries = numFormatPkg::LookupSize;

    // Sample value at each table index
    logic [Nw-1:0] baseTable [Entries];

    // Drop from one sample to the next, the curve falls monotonically
    logic [Nw-1:0] slopeTable [Entries];

    numFormatPkg::recipOperand_t operand;

    logic [Nw-1:0]    base;
    logic [Nw-1:0]    slope;
    logic [Nw+Iw-1:0] slopeProduct;

    // Same word seen in its decoded form below
    assign operand.raw = x;

    assign base  = baseTable[operand.fields.index];
    assign slope = slopeTable[operand.fields.index];

    // Slope times the fraction, the fraction counts in steps of 1/2^Iw
    assign slopeProduct = slope * operand.fields.frac;

    // Walk down from the sample by the scaled slope and keep the low bits
    assign y = base - slopeProduct[Iw +: Nw];

    // Tables are filled at elaboration and end up as ROM
    initial
    begin
        int unsigned currentB;
        int unsigned nextB;
        int unsigned deltaB;

        for (int j = 0; j < Entries; j++)
        begin
            // NUMERATOR over j gives values 2^Iw times too large, so the
            // rounded quotient is scaled back down by the interpolation width
            if (j == 0)
            begin
                // No quotient exists at zero, start from the largest number
                currentB = (1 << Nw) - 1;
            end
            else
            begin
                currentB = ((NUMERATOR / j) + (1 << (Iw - 1))) >> Iw;
            end
            nextB = ((NUMERATOR / (j + 1)) + (1 << (Iw - 1))) >> Iw;

            // Kept modulo the number width like the final subtraction
            deltaB = currentB - nextB;

            baseTable[j]  = currentB[Nw-1:0];
            slopeTable[j] = deltaB[Nw-1:0];
        end
    end

endmodule

/* design/perspectiveDivide.sv */
// Three stage stalling pipeline that recovers w and multiplies it into s/w and t/w
`timescale 1ns/1ps

module perspectiveDivide #(
    parameter int unsigned NUMERATOR = numFormatPkg::DefaultNumerator
)
(
    input  logic                                 aclk,
    input  logic                                 rst,

    // Fragment stream from the interpolators
    input  logic                                 sValid,
    output logic                                 sReady,
    input  logic [numFormatPkg::NumberWidth-1:0] invW,
    input  logic [numFormatPkg::NumberWidth-1:0] sOverW,
    input  logic [numFormatPkg::NumberWidth-1:0] tOverW,
    input  texCoordPkg::wrapMode_t               wrapModeIn,

    // Perspective corrected coordinates
    output logic                                 mValid,
    input  logic                                 mReady,
    output logic [numFormatPkg::NumberWidth-1:0] sCoord,
    output logic [numFormatPkg::NumberWidth-1:0] tCoord,
    output texCoordPkg::wrapMode_t               wrapModeOut
);

    localparam int Nw = numFormatPkg::NumberWidth;

    // Products carry 2*Nw bits, keep the window that leaves CoordFracBits of fraction
    localparam int ProductShift = Nw - texCoordPkg::CoordFracBits;

    logic advance1;
    logic advance2;
    logic advance3;
    logic valid1;
    logic valid2;
    logic valid3;

    // Stage 1 holds the raw fragment
    logic [Nw-1:0]          invW1;
    logic [Nw-1:0]          sOverW1;
    logic [Nw-1:0]          tOverW1;
    texCoordPkg::wrapMode_t wrap1;

    // Stage 2 holds w next to the values it scales
    logic [Nw-1:0]          recipW;
    logic [Nw-1:0]          w2;
    logic [Nw-1:0]          sOverW2;
    logic [Nw-1:0]          tOverW2;
    texCoordPkg::wrapMode_t wrap2;

    logic [2*Nw-1:0] sProduct;
    logic [2*Nw-1:0] tProduct;

    // A stage moves when it is empty or the one after it moves
    assign advance3 = ~valid3 | mReady;
    assign advance2 = ~valid2 | advance3;
    assign advance1 = ~valid1 | advance2;

    assign sReady = advance1;
    assign mValid = valid3;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
        end
        else
        begin
            if (advance1) valid1 <= sValid;
            if (advance2) valid2 <= valid1;
            if (advance3) valid3 <= valid2;
        end
    end

    recip #(
        .NUMERATOR(NUMERATOR)
    ) recip_inst (
        .x(invW1),
        .y(recipW)
    );

    assign sProduct = sOverW2 * w2;
    assign tProduct = tOverW2 * w2;

    // The wrap mode rides along so each fragment keeps its own
    always_ff @(posedge aclk)
    begin
        if (advance1)
        begin
            invW1   <= invW;
            sOverW1 <= sOverW;
            tOverW1 <= tOverW;
            wrap1   <= wrapModeIn;
        end
        if (advance2)
        begin
            w2      <= recipW;
            sOverW2 <= sOverW1;
            tOverW2 <= tOverW1;
            wrap2   <= wrap1;
        end
        if (advance3)
        begin
            sCoord      <= sProduct[ProductShift +: Nw];
            tCoord      <= tProduct[ProductShift +: Nw];
            wrapModeOut <= wrap2;
        end
    end

endmodule

/* design/texCoordWrap.sv */
// Registered conversion of s and t into texel indices by repeat or clamp
`timescale 1ns/1ps

module texCoordWrap #(
    // Texture edge length is 2^TEX_SIZE_LOG2 texels
    parameter int TEX_SIZE_LOG2 = 6
)
(
    input  logic                                 aclk,
    input  logic                                 rst,

    input  logic                                 sValid,
    output logic                                 sReady,
    input  logic [numFormatPkg::NumberWidth-1:0] sCoord,
    input  logic [numFormatPkg::NumberWidth-1:0] tCoord,
    input  texCoordPkg::wrapMode_t               wrapMode,

    output logic                                 mValid,
    input  logic                                 mReady,
    output logic [TEX_SIZE_LOG2-1:0]             texelU,
    output logic [TEX_SIZE_LOG2-1:0]             texelV
);

    localparam int Nw = numFormatPkg::NumberWidth;
    localparam int FracBits = texCoordPkg::CoordFracBits;
    localparam int IntBits = texCoordPkg::CoordIntBits;

    // Index of the last texel along one axis
    localparam logic [IntBits-1:0] TexMax = IntBits'((1 << TEX_SIZE_LOG2) - 1);

    logic advance;

    // Fraction is dropped, then the integer part is folded into the texture
    function automatic logic [TEX_SIZE_LOG2-1:0] wrapCoord(
        input logic [Nw-1:0]           coord,
        input texCoordPkg::wrapMode_t  mode
    );
        logic [IntBits-1:0] intPart;

        intPart = coord[FracBits +: IntBits];
        if (mode == texCoordPkg::WrapClamp && intPart > TexMax)
            wrapCoord = '1;
        else
            wrapCoord = intPart[TEX_SIZE_LOG2-1:0];
    endfunction

    // Output register accepts when empty or when it is being drained
    assign advance = ~mValid | mReady;
    assign sReady  = advance;

    always_ff @(posedge aclk)
    begin
        if (rst)
            mValid <= 1'b0;
        else if (advance)
            mValid <= sValid;
    end

    always_ff @(posedge aclk)
    begin
        if (advance)
        begin
            texelU <= wrapCoord(sCoord, wrapMode);
            texelV <= wrapCoord(tCoord, wrapMode);
        end
    end

endmodule

/* design/texturePerspectiveTop.sv */
// Perspective correction of texture coordinates followed by texel wrapping
`timescale 1ns/1ps

module texturePerspectiveTop #(
    // Reciprocal numerator handed down to the divider
    parameter int unsigned NUMERATOR = numFormatPkg::DefaultNumerator,
    // Texture edge length as a power of two
    parameter int TEX_SIZE_LOG2 = 6
)
(
    input  logic                                 aclk,
    input  logic                                 rst,

    // Interpolated fragment attributes
    input  logic                                 sValid,
    output logic                                 sReady,
    input  logic [numFormatPkg::NumberWidth-1:0] invW,
    input  logic [numFormatPkg::NumberWidth-1:0] sOverW,
    input  logic [numFormatPkg::NumberWidth-1:0] tOverW,
    input  texCoordPkg::wrapMode_t               wrapMode,

    // Texel indices toward texture memory
    output logic                                 mValid,
    input  logic                                 mReady,
    output logic [TEX_SIZE_LOG2-1:0]             texelU,
    output logic [TEX_SIZE_LOG2-1:0]             texelV
);

    // Stream between the divider and the wrap stage
    logic                                 pdValid;
    logic                                 pdReady;
    logic [numFormatPkg::NumberWidth-1:0] sCoord;
    logic [numFormatPkg::NumberWidth-1:0] tCoord;
    texCoordPkg::wrapMode_t               pdWrapMode;

    // Three register stages that recover s and t
    perspectiveDivide #(
        .NUMERATOR(NUMERATOR)
    ) perspectiveDivide_inst (
        .aclk(aclk),
        .rst(rst),
        .sValid(sValid),
        .sReady(sReady),
        .invW(invW),
        .sOverW(sOverW),
        .tOverW(tOverW),
        .wrapModeIn(wrapMode),
        .mValid(pdValid),
        .mReady(pdReady),
        .sCoord(sCoord),
        .tCoord(tCoord),
        .wrapModeOut(pdWrapMode)
    );

    // One more register that turns coordinates into texel indices
    texCoordWrap #(
        .TEX_SIZE_LOG2(TEX_SIZE_LOG2)
    ) texCoordWrap_inst (
        .aclk(aclk),
        .rst(rst),
        .sValid(pdValid),
        .sReady(pdReady),
        .sCoord(sCoord),
        .tCoord(tCoord),
        .wrapMode(pdWrapMode),
        .mValid(mValid),
        .mReady(mReady),
        .texelU(texelU),
        .texelV(texelV)
    );

endmodule

/* verif/recipRefModel.svh */
// Reference model of the reciprocal table, the perspective multiply and the texel wrap
`ifndef RECIP_REF_MODEL_SVH
`define RECIP_REF_MODEL_SVH

// Samples and slopes rebuilt from the numerator before any beat is sent
logic [Nw-1:0] refBase [Entries];
logic [Nw-1:0] refSlope [Entries];

// Numerator over a sample position, rounded and scaled down to table units
function automatic longint roundedQuotient(input int j);
    return (longint'(Numerator) / j + 2 ** (Iw - 1)) / 2 ** Iw;
endfunction

task automatic buildRefTables();
    longint sample;
    for (int j = 0; j < Entries; j++)
    begin
        // Position zero has no quotient and starts at the largest number
        sample = (j == 0) ? longint'(2 ** Nw - 1) : roundedQuotient(j);
        refBase[j]  = Nw'(sample);
        // Slopes wrap modulo the number width in the same way as the samples
        refSlope[j] = Nw'(sample - roundedQuotient(j + 1));
    end
endtask

function automatic logic [Nw-1:0] refRecip(input logic [Nw-1:0] x);
    logic [Lp-1:0]    index;
    logic [Iw-1:0]    frac;
    logic [Nw+Iw-1:0] drop;
    index = x[Nw-1 -: Lp];
    frac  = x[Iw-1:0];
    // The fraction counts in steps of 1/2^Iw between two samples
    drop = (Nw+Iw)'(refSlope[index]) * (Nw+Iw)'(frac);
    return refBase[index] - drop[Iw +: Nw];
endfunction

// Product of a per-w value and w, keeping FracBits of fraction
function automatic logic [Nw-1:0] refCoord(input logic [Nw-1:0] overW, input logic [Nw-1:0] w);
    logic [2*Nw-1:0] product;
    product = (2*Nw)'(overW) * (2*Nw)'(w);
    return product[Nw - FracBits +: Nw];
endfunction

function automatic logic [TexSizeLog2-1:0] refWrap(input logic [Nw-1:0] coord,
                                                    input texCoordPkg::wrapMode_t mode);
    int intPart;
    intPart = int'(coord >> FracBits);
    if (mode == texCoordPkg::WrapClamp && intPart >= 2 ** TexSizeLog2)
        return '1;
    return TexSizeLog2'(intPart);
endfunction

`endif

/* verif/texturePerspectiveTb.sv */
// Testbench for the perspective correction and texel wrap pipeline
`timescale 1ns/1ps

module texturePerspectiveTb;

    localparam int Nw = numFormatPkg::NumberWidth;
    localparam int Iw = numFormatPkg::InterpolationWidth;
    localparam int Lp = numFormatPkg::LookupPrecision;
    localparam int Entries = numFormatPkg::LookupSize;
    localparam int FracBits = texCoordPkg::CoordFracBits;
    localparam int unsigned Numerator = numFormatPkg::DefaultNumerator;
    localparam int TexSizeLog2 = 6;
    localparam int ClockPeriod = 20;

    // The run limit grows with the sum of the beats per test
    localparam int EdgeBeats = 8;
    localparam int StreamBeats = 200;
    localparam int PressureBeats = 100;
    localparam int WrapBeats = 16;
    localparam int TotalBeats = 1 + EdgeBeats + StreamBeats + PressureBeats + WrapBeats;
    localparam int TimeoutCycles = 2 * TotalBeats + 200;

    logic                     aclk;
    logic                     rst;
    logic                     sValid;
    logic                     sReady;
    logic [Nw-1:0]            invW;
    logic [Nw-1:0]            sOverW;
    logic [Nw-1:0]            tOverW;
    texCoordPkg::wrapMode_t   wrapMode;
    logic                     mValid;
    logic                     mReady;
    logic [TexSizeLog2-1:0]   texelU;
    logic [TexSizeLog2-1:0]   texelV;

    // Separate LFSR states so that ready steps leave the stimulus sequence unchanged
    logic [31:0] dataLfsr;
    logic [31:0] readyLfsr;
    logic        randomReady;

    int cycles = 0;
    int acceptCycle;
    int outputCycle;

    // Last stalled output beat must not change until it is taken
    logic                   holding;
    logic [TexSizeLog2-1:0] heldU;
    logic [TexSizeLog2-1:0] heldV;

    // Expected texel pairs in order of acceptance with U in the upper half
    logic [2*TexSizeLog2-1:0] expected [$];
    logic [2*TexSizeLog2-1:0] expectedPair;

    `include "recipRefModel.svh"

    texturePerspectiveTop #(
        .NUMERATOR(Numerator),
        .TEX_SIZE_LOG2(TexSizeLog2)
    ) texturePerspectiveTop_inst (
        .aclk(aclk),
        .rst(rst),
        .sValid(sValid),
        .sReady(sReady),
        .invW(invW),
        .sOverW(sOverW),
        .tOverW(tOverW),
        .wrapMode(wrapMode),
        .mValid(mValid),
        .mReady(mReady),
        .texelU(texelU),
        .texelV(texelV)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(ClockPeriod / 2) aclk = ~aclk;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expectedValue);
        if (actual !== expectedValue)
        begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, actual, expectedValue);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Fibonacci LFSR with taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Collects n bits from the stimulus LFSR with one step per bit
    task automatic randomBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            dataLfsr = lfsrStep(dataLfsr);
            value = {value[30:0], dataLfsr[0]};
        end
    endtask

    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles)
            failRun($sformatf("Timeout after %0d cycles with beats still pending", cycles));
    end

    // Pseudo-random back-pressure runs only while a test asks for it
    always @(posedge aclk)
    begin
        #1;
        if (randomReady)
        begin
            readyLfsr = lfsrStep(readyLfsr);
            mReady = readyLfsr[0];
        end
    end

    // Watches both streams at each edge before the DUT registers move
    always @(posedge aclk)
    begin
        if (!rst && sValid && sReady)
        begin
            expected.push_back({refWrap(refCoord(sOverW, refRecip(invW)), wrapMode),
                                refWrap(refCoord(tOverW, refRecip(invW)), wrapMode)});
            acceptCycle = cycles;
        end
        if (holding)
        begin
            checkValue("mValid", mValid, 1);
            checkValue("texelU", texelU, heldU);
            checkValue("texelV", texelV, heldV);
        end
        if (mValid && mReady)
        begin
            if (expected.size() == 0)
                failRun("An output beat came out with no input beat left to match it");
            else
            begin
                expectedPair = expected.pop_front();
                checkValue("texelU", texelU, expectedPair[2*TexSizeLog2-1 -: TexSizeLog2]);
                checkValue("texelV", texelV, expectedPair[TexSizeLog2-1:0]);
                outputCycle = cycles;
            end
        end
        holding = mValid && !mReady;
        heldU = texelU;
        heldV = texelV;
    end

    // Holds one beat on the inputs until the DUT takes it
    task automatic sendBeat(input logic [Nw-1:0] inv, input logic [Nw-1:0] s,
                            input logic [Nw-1:0] t, input texCoordPkg::wrapMode_t mode);
        invW = inv;
        sOverW = s;
        tOverW = t;
        wrapMode = mode;
        sValid = 1'b1;
        do
            @(posedge aclk);
        while (!sReady);
        #1;
        sValid = 1'b0;
    endtask

    task automatic sendRandomBeat();
        logic [31:0] inv;
        logic [31:0] s;
        logic [31:0] t;
        logic [31:0] m;
        randomBits(Nw, inv);
        randomBits(Nw, s);
        randomBits(Nw, t);
        randomBits(1, m);
        sendBeat(inv[Nw-1:0], s[Nw-1:0], t[Nw-1:0], texCoordPkg::wrapMode_t'(m[0]));
    endtask

    task automatic waitDrain();
        while (expected.size() != 0)
        begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic checkReset();
        checkValue("mValid", mValid, 0);
        checkValue("sReady", sReady, 1);
    endtask

    task automatic singleBeatTest();
        mReady = 1'b1;
        sendBeat(16'h1234, 16'h0456, 16'h0789, texCoordPkg::WrapRepeat);
        waitDrain();
        // Four register stages between the input and output handshakes
        checkValue("latency", outputCycle - acceptCycle, 4);
    endtask

    // Operands at index 0 and at the top of the table, plus the truncated low samples
    task automatic tableEdgeTest();
        logic [Nw-1:0] edgeInv [EdgeBeats] = '{16'h0000, 16'h001F, 16'h0001, 16'h0020,
                                               16'h0100, 16'hFFE0, 16'hFFDF, 16'hFFFF};
        logic [31:0] s;
        logic [31:0] t;
        for (int i = 0; i < EdgeBeats; i++)
        begin
            randomBits(Nw, s);
            randomBits(Nw, t);
            sendBeat(edgeInv[i], s[Nw-1:0], t[Nw-1:0], texCoordPkg::wrapMode_t'(i % 2));
        end
        waitDrain();
    endtask

    task automatic streamTest();
        int startCycle;
        mReady = 1'b1;
        startCycle = cycles;
        for (int i = 0; i < StreamBeats; i++)
            sendRandomBeat();
        // With no stall every edge takes exactly one beat
        checkValue("streamCycles", cycles - startCycle, StreamBeats);
        waitDrain();
    endtask

    task automatic pressureTest();
        randomReady = 1'b1;
        for (int i = 0; i < PressureBeats; i++)
            sendRandomBeat();
        waitDrain();
        randomReady = 1'b0;
        mReady = 1'b1;
    endtask

    // Operand 0x0800 gives w = 8192, so the integer parts climb past the texture edge
    task automatic wrapTest();
        mReady = 1'b1;
        for (int i = 0; i < WrapBeats; i++)
            sendBeat(16'h0800, Nw'(300 + 40 * i), Nw'(20 + 70 * i),
                     texCoordPkg::wrapMode_t'(i % 2));
        waitDrain();
    endtask

    initial
    begin
        rst = 1'b1;
        sValid = 1'b0;
        invW = '0;
        sOverW = '0;
        tOverW = '0;
        wrapMode = texCoordPkg::WrapRepeat;
        mReady = 1'b1;
        randomReady = 1'b0;
        dataLfsr = 32'hb1139847;
        readyLfsr = 32'hb1139847;
        holding = 1'b0;
        buildRefTables();
        repeat (4) @(posedge aclk);
        #1;
        rst = 1'b0;
        checkReset();
        singleBeatTest();
        tableEdgeTest();
        streamTest();
        pressureTest();
        wrapTest();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verif
design/numFormatPkg.sv
design/texCoordPkg.sv
design/recip.sv
design/perspectiveDivide.sv
design/texCoordWrap.sv
design/texturePerspectiveTop.sv
verif/texturePerspectiveTb.sv

/* Makefile */
TOP := texturePerspectiveTb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module texturePerspectiveTop

clean:
	rm -rf obj_dir
